// ==== Bender.yml ====
package:
  name: snes_cart

sources:
  - include_dirs:
      - design
    files:
      - design/snes_cart_pkg.sv
      - design/sample_delay.sv
      - design/snes_bus_sync.sv
      - design/mcu_rom_arbiter.sv
      - design/bright_limiter.sv
      - design/rom_bus_mux.sv
      - design/snes_cart_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_snes_cart_asserts.sv
      - test/tb_snes_cart.sv

// ==== design/bright_limiter.sv ====
`timescale 1ns/1ps
`include "snes_cart_params.svh"

module bright_limiter (
  input  logic                      CLK2,
  input  logic                      rst_n,
  input  snes_cart_pkg::snes_addr_t snes_addr,
  input  snes_cart_pkg::byte_t      snes_data,
  input  logic                      pawr_start,
  input  logic                      cycle_end,
  input  snes_cart_pkg::bright_t    bright_limit,
  output logic                      force_write,
  output snes_cart_pkg::byte_t      forced_data
);
  import snes_cart_pkg::*;

  bright_t level;
  logic    inidisp_hit;
  logic    limit_on;
  logic    arm;
  logic    force_pre;

  assign level       = snes_data[3:0];
  assign inidisp_hit = {snes_addr[22], snes_addr[15:0]} == `REG_INIDISP;
  assign limit_on    = ~&bright_limit;  // 15 means full brightness allowed
  assign arm         = pawr_start & inidisp_hit & limit_on & (level > bright_limit);

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      force_pre   <= 1'b0;
      force_write <= 1'b0;
    end else begin
      force_write <= force_pre;  // Extra stage lets the data settle
      if (cycle_end) begin
        force_pre <= 1'b0;
      end else if (arm) begin
        force_pre <= 1'b1;
      end
    end
  end

  // Keep force blank bit, tag 0x4x/0xCx, clamp brightness
  always_ff @(posedge CLK2) begin
    if (arm) begin
      forced_data <= {snes_data[7], 3'b100, bright_limit};
    end
  end

endmodule

// ==== design/mcu_rom_arbiter.sv ====
`timescale 1ns/1ps
`include "snes_cart_params.svh"

module mcu_rom_arbiter (
  input  logic                      CLK2,
  input  logic                      rst_n,
  input  logic                      mcu_rrq,
  input  logic                      mcu_wrq,
  input  snes_cart_pkg::snes_addr_t mcu_addr,
  input  logic                      free_slot,
  input  logic                      snes_dead,
  input  logic                      cpu_clk_level,
  input  snes_cart_pkg::byte_t      rom_rd_byte,
  output logic                      mcu_rdy,
  output logic                      mcu_hit_rd,
  output logic                      mcu_hit_wr,
  output snes_cart_pkg::snes_addr_t access_addr,
  output snes_cart_pkg::byte_t      mcu_rdata
);
  import snes_cart_pkg::*;

  localparam int dly_w = $clog2(`ROM_CYCLE_LEN + 1);

  arb_state_t       state;
  logic [dly_w-1:0] delay;
  logic             rd_pend;
  logic             wr_pend;
  logic             accept;
  logic             access_done;
  logic             wake_up;

  assign accept      = mcu_rdy & (mcu_rrq | mcu_wrq);
  assign access_done = (state == st_rd_end) || (state == st_wr_end);
  assign wake_up     = snes_dead & cpu_clk_level;  // First CPU clock after dead
  assign mcu_hit_rd  = state == st_rd_addr;
  assign mcu_hit_wr  = state == st_wr_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Request side

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rdy && mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_rdy && mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (accept) begin
      access_addr <= mcu_addr;
    end
    if (mcu_hit_rd) begin
      mcu_rdata <= rom_rd_byte;  // Last sample before rd_end wins
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Access FSM

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      delay <= '0;
    end else if (wake_up) begin
      state <= st_idle;  // Abandon, pending flag stays set
    end else begin
      case (state)
        st_idle: begin
          delay <= dly_w'(`ROM_CYCLE_LEN);
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state <= st_rd_addr;
            end else if (wr_pend) begin
              state <= st_wr_addr;
            end
          end
        end
        st_rd_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= st_rd_end;
          end
        end
        st_wr_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= st_wr_end;
          end
        end
        default: begin
          state <= st_idle;  // Both end states
        end
      endcase
    end
  end

endmodule

// ==== design/rom_bus_mux.sv ====
`timescale 1ns/1ps

module rom_bus_mux (
  input  snes_cart_pkg::snes_addr_t snes_addr,
  input  snes_cart_pkg::snes_addr_t rom_mask,
  input  snes_cart_pkg::snes_addr_t access_addr,
  input  snes_cart_pkg::byte_t      mcu_wdata,
  input  snes_cart_pkg::byte_t      snes_data,
  input  logic [15:0]               rom_dq_in,
  input  logic                      romsel_active,
  input  logic                      wr_active,
  input  logic                      rd_active,
  input  logic                      pawr_active,
  input  logic                      cpu_clk_level,
  input  logic                      mcu_hit_rd,
  input  logic                      mcu_hit_wr,
  input  logic                      force_write,
  input  snes_cart_pkg::byte_t      forced_data,
  output snes_cart_pkg::rom_addr_t  rom_addr,
  output logic                      rom_bhe,
  output logic                      rom_ble,
  output logic                      rom_we,
  output logic [15:0]               rom_dq_out,
  output logic                      rom_dq_oe,
  output snes_cart_pkg::byte_t      rom_rd_byte,
  output snes_cart_pkg::byte_t      snes_data_out,
  output logic                      snes_data_oe
);
  import snes_cart_pkg::*;

  snes_addr_t sel_addr;
  byte_t      wr_byte;
  logic       use_mcu;
  logic       snes_wr_rom;
  logic       mcu_wr_rom;
  logic       drive_forced;

  // Console ROM hit wins over the MCU
  assign use_mcu  = (mcu_hit_rd | mcu_hit_wr) & ~romsel_active;
  assign sel_addr = use_mcu ? access_addr : (snes_addr & rom_mask);

  assign rom_addr = sel_addr[$bits(snes_addr_t)-1:1];
  assign rom_bhe  = sel_addr[0];   // Odd byte sits in the low lane
  assign rom_ble  = ~sel_addr[0];

  assign snes_wr_rom = romsel_active & wr_active & cpu_clk_level;
  assign mcu_wr_rom  = use_mcu & mcu_hit_wr;

  assign rom_we     = ~(snes_wr_rom | mcu_wr_rom);
  assign wr_byte    = snes_wr_rom ? snes_data : mcu_wdata;
  assign rom_dq_out = {wr_byte, wr_byte};  // Lane selects pick the byte
  assign rom_dq_oe  = snes_wr_rom | mcu_wr_rom;

  assign rom_rd_byte = sel_addr[0] ? rom_dq_in[7:0] : rom_dq_in[15:8];

  ////////////////////////////////////////////////////////////////////////////
  // Console data bus

  assign drive_forced  = force_write & pawr_active;
  assign snes_data_out = drive_forced ? forced_data : rom_rd_byte;
  assign snes_data_oe  = drive_forced | (romsel_active & rd_active);

endmodule

// ==== design/sample_delay.sv ====
`timescale 1ns/1ps
`include "snes_cart_params.svh"

module sample_delay #(
  parameter type T = logic [7:0]
) (
  input  logic CLK2,
  input  logic rst_n,
  input  T     d,
  output T     q
);

  localparam int depth = `SAMPLE_DEPTH;

  T stage [depth];  // stage[0] holds the newest sample

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        stage[i] <= '1;  // Idle bus reads high
      end
    end else begin
      stage[0] <= d;
      for (int i = 1; i < depth; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // Both oldest samples must agree on a 1
  assign q = stage[depth-1] & stage[depth-2];

endmodule

// ==== design/snes_bus_sync.sv ====
`timescale 1ns/1ps
`include "snes_cart_params.svh"

module snes_bus_sync (
  input  logic                      CLK2,
  input  logic                      rst_n,
  input  snes_cart_pkg::snes_addr_t snes_addr_in,
  input  snes_cart_pkg::byte_t      snes_data_in,
  input  logic                      snes_rd_n,
  input  logic                      snes_wr_n,
  input  logic                      snes_pawr_n,
  input  logic                      snes_cpu_clk,
  input  logic                      snes_romsel_n,
  output snes_cart_pkg::snes_addr_t snes_addr,
  output snes_cart_pkg::byte_t      snes_data,
  output logic                      rd_active,
  output logic                      wr_active,
  output logic                      pawr_active,
  output logic                      romsel_active,
  output logic                      cpu_clk_level,
  output logic                      rd_start,
  output logic                      wr_end,
  output logic                      pawr_start,
  output logic                      cycle_start,
  output logic                      cycle_end,
  output logic                      free_slot,
  output logic                      snes_dead
);
  import snes_cart_pkg::*;

  localparam int d     = `SAMPLE_DEPTH;
  localparam int cnt_w = $clog2(`SNES_DEAD_TIMEOUT + 1);

  // Patterns on history bits d-1..1, oldest on the left
  localparam logic [d-2:0] fall_pat   = {{(d-2){1'b1}}, 1'b0};
  localparam logic [d-2:0] rise_pat   = {{(d-2){1'b0}}, 1'b1};
  localparam logic [d-2:0] pawr_early = {{(d-4){1'b1}}, 3'b000};
  localparam logic [d-2:0] pawr_late  = {1'b1, {(d-2){1'b0}}};

  logic [d-1:0]     rd_r;
  logic [d-1:0]     wr_r;
  logic [d-1:0]     pawr_r;
  logic [d-1:0]     clk_r;
  logic [d-1:0]     romsel_r;
  logic [cnt_w-1:0] dead_cnt;
  logic             free_strobe;
  logic             inidisp_addr;

  sample_delay #(.T(snes_addr_t)) u_addr_delay (
    .CLK2 (CLK2),
    .rst_n(rst_n),
    .d    (snes_addr_in),
    .q    (snes_addr)
  );

  sample_delay #(.T(byte_t)) u_data_delay (
    .CLK2 (CLK2),
    .rst_n(rst_n),
    .d    (snes_data_in),
    .q    (snes_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Strobe histories, bit 0 newest

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_r     <= '1;
      wr_r     <= '1;
      pawr_r   <= '1;
      romsel_r <= '1;
      clk_r    <= '0;
    end else begin
      rd_r     <= {rd_r[d-2:0], snes_rd_n};
      wr_r     <= {wr_r[d-2:0], snes_wr_n};
      pawr_r   <= {pawr_r[d-2:0], snes_pawr_n};
      romsel_r <= {romsel_r[d-2:0], snes_romsel_n};
      clk_r    <= {clk_r[d-2:0], snes_cpu_clk};
    end
  end

  assign rd_active     = ~(rd_r[2] & rd_r[1]);
  assign wr_active     = ~(wr_r[2] & wr_r[1]);
  assign pawr_active   = ~(pawr_r[2] & pawr_r[1]);
  assign cpu_clk_level = clk_r[2] & clk_r[1];
  // Taken later so it lines up with the filtered address
  assign romsel_active = ~(romsel_r[d-2] & romsel_r[d-3]);

  assign inidisp_addr = {snes_addr[22], snes_addr[15:0]} == `REG_INIDISP;

  assign rd_start    = rd_r[d-1:1] == fall_pat;
  assign wr_end      = wr_r[d-1:1] == rise_pat;
  assign cycle_start = clk_r[d-1:1] == rise_pat;
  assign cycle_end   = clk_r[d-1:1] == fall_pat;
  // INIDISP data is taken early, other B-bus writes late for DMA
  assign pawr_start  = pawr_r[d-1:1] == (inidisp_addr ? pawr_early : pawr_late);

  ////////////////////////////////////////////////////////////////////////////
  // Free slots and dead console

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~romsel_active;  // No ROM hit this cycle
    end
  end

  assign free_slot = cycle_end | free_strobe;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else if (cpu_clk_level) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else if (dead_cnt == cnt_w'(`SNES_DEAD_TIMEOUT)) begin
      snes_dead <= 1'b1;  // Counter parks here
    end else begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

endmodule

// ==== design/snes_cart_params.svh ====
`ifndef SNES_CART_PARAMS_SVH
`define SNES_CART_PARAMS_SVH

// Bus widths
`define SNES_ADDR_W 24
`define ROM_ADDR_W 23

// Strobe history length in CLK2 cycles
`define SAMPLE_DEPTH 7

// Delay count of one MCU access to the PSRAM
`define ROM_CYCLE_LEN 8

// About 1 ms of CLK2 without a CPU clock high
`define SNES_DEAD_TIMEOUT 96000

// INIDISP as {A22, A15..A0}
`define REG_INIDISP 17'h02100

`endif

// ==== design/snes_cart_pkg.sv ====
`include "snes_cart_params.svh"

package snes_cart_pkg;

  typedef logic [`SNES_ADDR_W-1:0] snes_addr_t;  // Console A23..A0
  typedef logic [7:0]              byte_t;
  typedef logic [`ROM_ADDR_W-1:0]  rom_addr_t;   // 16-bit word address
  typedef logic [3:0]              bright_t;     // INIDISP brightness

  // Arbiter states, one-hot
  typedef enum logic [4:0] {
    st_idle    = 5'b00001,
    st_rd_addr = 5'b00010,
    st_rd_end  = 5'b00100,
    st_wr_addr = 5'b01000,
    st_wr_end  = 5'b10000
  } arb_state_t;

endpackage

// ==== design/snes_cart_top.sv ====
`timescale 1ns/1ps

module snes_cart_top (
  input  logic                      CLK2,
  input  logic                      rst_n,
  // Console bus
  input  snes_cart_pkg::snes_addr_t snes_addr_in,
  input  snes_cart_pkg::byte_t      snes_data_in,
  output snes_cart_pkg::byte_t      snes_data_out,
  output logic                      snes_data_oe,
  input  logic                      snes_rd_n,
  input  logic                      snes_wr_n,
  input  logic                      snes_pawr_n,
  input  logic                      snes_cpu_clk,
  input  logic                      snes_romsel_n,
  // MCU side
  input  logic                      mcu_rrq,
  input  logic                      mcu_wrq,
  input  snes_cart_pkg::snes_addr_t mcu_addr,
  input  snes_cart_pkg::byte_t      mcu_wdata,
  output logic                      mcu_rdy,
  output snes_cart_pkg::byte_t      mcu_rdata,
  input  snes_cart_pkg::snes_addr_t rom_mask,
  input  snes_cart_pkg::bright_t    bright_limit,
  // PSRAM
  output snes_cart_pkg::rom_addr_t  rom_addr,
  output logic                      rom_bhe,
  output logic                      rom_ble,
  output logic                      rom_we,
  input  logic [15:0]               rom_dq_in,
  output logic [15:0]               rom_dq_out,
  output logic                      rom_dq_oe
);
  import snes_cart_pkg::*;

  snes_addr_t snes_addr;
  snes_addr_t access_addr;
  byte_t      snes_data;
  byte_t      rom_rd_byte;
  byte_t      forced_data;
  logic       rd_active;
  logic       wr_active;
  logic       pawr_active;
  logic       romsel_active;
  logic       cpu_clk_level;
  logic       rd_start;
  logic       wr_end;
  logic       pawr_start;
  logic       cycle_start;
  logic       cycle_end;
  logic       free_slot;
  logic       snes_dead;
  logic       mcu_hit_rd;
  logic       mcu_hit_wr;
  logic       force_write;

  ////////////////////////////////////////////////////////////////////////////
  // Decode

  snes_bus_sync u_bus_sync (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_addr_in (snes_addr_in),
    .snes_data_in (snes_data_in),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_pawr_n  (snes_pawr_n),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_romsel_n(snes_romsel_n),
    .snes_addr    (snes_addr),
    .snes_data    (snes_data),
    .rd_active    (rd_active),
    .wr_active    (wr_active),
    .pawr_active  (pawr_active),
    .romsel_active(romsel_active),
    .cpu_clk_level(cpu_clk_level),
    .rd_start     (rd_start),
    .wr_end       (wr_end),
    .pawr_start   (pawr_start),
    .cycle_start  (cycle_start),
    .cycle_end    (cycle_end),
    .free_slot    (free_slot),
    .snes_dead    (snes_dead)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute

  mcu_rom_arbiter u_arbiter (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .free_slot    (free_slot),
    .snes_dead    (snes_dead),
    .cpu_clk_level(cpu_clk_level),
    .rom_rd_byte  (rom_rd_byte),
    .mcu_rdy      (mcu_rdy),
    .mcu_hit_rd   (mcu_hit_rd),
    .mcu_hit_wr   (mcu_hit_wr),
    .access_addr  (access_addr),
    .mcu_rdata    (mcu_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result

  bright_limiter u_bright (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .snes_addr   (snes_addr),
    .snes_data   (snes_data),
    .pawr_start  (pawr_start),
    .cycle_end   (cycle_end),
    .bright_limit(bright_limit),
    .force_write (force_write),
    .forced_data (forced_data)
  );

  rom_bus_mux u_mux (
    .snes_addr    (snes_addr),
    .rom_mask     (rom_mask),
    .access_addr  (access_addr),
    .mcu_wdata    (mcu_wdata),
    .snes_data    (snes_data),
    .rom_dq_in    (rom_dq_in),
    .romsel_active(romsel_active),
    .wr_active    (wr_active),
    .rd_active    (rd_active),
    .pawr_active  (pawr_active),
    .cpu_clk_level(cpu_clk_level),
    .mcu_hit_rd   (mcu_hit_rd),
    .mcu_hit_wr   (mcu_hit_wr),
    .force_write  (force_write),
    .forced_data  (forced_data),
    .rom_addr     (rom_addr),
    .rom_bhe      (rom_bhe),
    .rom_ble      (rom_ble),
    .rom_we       (rom_we),
    .rom_dq_out   (rom_dq_out),
    .rom_dq_oe    (rom_dq_oe),
    .rom_rd_byte  (rom_rd_byte),
    .snes_data_out(snes_data_out),
    .snes_data_oe (snes_data_oe)
  );

endmodule

// ==== sim.f ====
+incdir+design
design/snes_cart_pkg.sv
design/sample_delay.sv
design/snes_bus_sync.sv
design/mcu_rom_arbiter.sv
design/bright_limiter.sv
design/rom_bus_mux.sv
design/snes_cart_top.sv
test/tb_snes_cart_asserts.sv
test/tb_snes_cart.sv

// ==== test/tb_snes_cart.sv ====
`timescale 1ns/1ps
`include "snes_cart_params.svh"

module tb_snes_cart;
  import snes_cart_pkg::*;

  localparam int rom_words     = 4096;
  localparam int low_len       = 8;   // Console clock low phase in CLK2 cycles
  localparam int high_len      = 10;
  localparam int console_len   = low_len + high_len;
  localparam int access_cycles = `ROM_CYCLE_LEN + 8;
  localparam int ready_limit   = access_cycles + 2 * console_len;
  localparam int reset_cycles  = 10;
  // Seven MCU accesses, eight console cycles, one slot wait
  localparam int test_cycles   = reset_cycles + 7 * access_cycles + 8 * console_len
                                 + console_len;
  localparam int run_limit     = 2 * test_cycles;

  localparam int k_idle = 0;
  localparam int k_read = 1;
  localparam int k_pawr = 2;

  logic        CLK2;
  logic        rst_n;
  snes_addr_t  snes_addr_in;
  byte_t       snes_data_in;
  byte_t       snes_data_out;
  logic        snes_data_oe;
  logic        snes_rd_n;
  logic        snes_wr_n;
  logic        snes_pawr_n;
  logic        snes_cpu_clk;
  logic        snes_romsel_n;
  logic        mcu_rrq;
  logic        mcu_wrq;
  snes_addr_t  mcu_addr;
  byte_t       mcu_wdata;
  logic        mcu_rdy;
  byte_t       mcu_rdata;
  snes_addr_t  rom_mask;
  bright_t     bright_limit;
  rom_addr_t   rom_addr;
  logic        rom_bhe;
  logic        rom_ble;
  logic        rom_we;
  logic [15:0] rom_dq_in;
  logic [15:0] rom_dq_out;
  logic        rom_dq_oe;

  logic [15:0] rom_mem [rom_words];
  int          cycle_cnt;
  int          checks;
  int          mismatches;
  int          other_errors;
  logic        seen_oe;       // Last console cycle drove the data bus
  byte_t       seen_data;
  rom_addr_t   seen_rom_addr;
  logic        console_busy;

  snes_cart_top u_dut (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_addr_in (snes_addr_in),
    .snes_data_in (snes_data_in),
    .snes_data_out(snes_data_out),
    .snes_data_oe (snes_data_oe),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .snes_pawr_n  (snes_pawr_n),
    .snes_cpu_clk (snes_cpu_clk),
    .snes_romsel_n(snes_romsel_n),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_addr     (mcu_addr),
    .mcu_wdata    (mcu_wdata),
    .mcu_rdy      (mcu_rdy),
    .mcu_rdata    (mcu_rdata),
    .rom_mask     (rom_mask),
    .bright_limit (bright_limit),
    .rom_addr     (rom_addr),
    .rom_bhe      (rom_bhe),
    .rom_ble      (rom_ble),
    .rom_we       (rom_we),
    .rom_dq_in    (rom_dq_in),
    .rom_dq_out   (rom_dq_out),
    .rom_dq_oe    (rom_dq_oe)
  );

  initial CLK2 = 1'b0;
  always #2 CLK2 = ~CLK2;

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model, lane selects active low

  assign rom_dq_in = rom_mem[rom_addr[11:0]];

  always @(posedge CLK2) begin
    if (rom_dq_oe && !rom_we) begin
      if (!rom_ble) rom_mem[rom_addr[11:0]][7:0] <= rom_dq_out[7:0];
      if (!rom_bhe) rom_mem[rom_addr[11:0]][15:8] <= rom_dq_out[15:8];
    end
  end

  always @(posedge CLK2) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= run_limit) begin
      $display("ERROR: run did not finish within %0d cycles", run_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Odd multiplier, so every address bit changes the word
  function automatic logic [15:0] fill_word(input int unsigned idx);
    logic [15:0] v;
    v = idx[15:0] * 16'h2f1b;
    return v ^ 16'ha55a;
  endfunction

  function automatic int word_idx(input snes_addr_t a);
    return int'(a[12:1]);
  endfunction

  // Odd byte in the low lane
  function automatic byte_t lane_byte(input logic [15:0] w, input logic odd);
    return odd ? w[7:0] : w[15:8];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input rom_addr_t exp, input rom_addr_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected 0x%06h, actual 0x%06h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    other_errors++;
    $display("ERROR: %s", msg);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers

  task automatic wait_mcu_ready(input string name);
    int n;
    n = 0;
    @(negedge CLK2);
    while (mcu_rdy !== 1'b1 && n < ready_limit) begin
      @(negedge CLK2);
      n++;
    end
    if (mcu_rdy !== 1'b1) begin
      report_error($sformatf("%s: mcu_rdy stayed low for %0d cycles", name, ready_limit));
    end
  endtask

  task automatic mcu_request(input logic is_write, input snes_addr_t addr, input byte_t wdata);
    @(posedge CLK2);
    mcu_rrq   <= !is_write;
    mcu_wrq   <= is_write;
    mcu_addr  <= addr;
    mcu_wdata <= wdata;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
  endtask

  task automatic mcu_access(input string name, input logic is_write, input snes_addr_t addr,
                            input byte_t wdata);
    wait_mcu_ready(name);
    mcu_request(is_write, addr, wdata);
    wait_mcu_ready(name);
  endtask

  // One console bus cycle, strobes during the clock high phase
  task automatic console_cycle(input int kind, input snes_addr_t addr, input byte_t data);
    @(posedge CLK2);
    snes_addr_in  <= addr;
    snes_data_in  <= data;
    snes_cpu_clk  <= 1'b0;
    snes_romsel_n <= (kind == k_read) ? 1'b0 : 1'b1;
    repeat (low_len) @(posedge CLK2);
    snes_cpu_clk <= 1'b1;
    if (kind == k_read) snes_rd_n <= 1'b0;
    if (kind == k_pawr) snes_pawr_n <= 1'b0;
    seen_oe = 1'b0;
    repeat (high_len) begin
      @(negedge CLK2);
      if (snes_data_oe === 1'b1) begin
        seen_oe       = 1'b1;
        seen_data     = snes_data_out;
        seen_rom_addr = rom_addr;
      end
      @(posedge CLK2);
    end
    snes_cpu_clk  <= 1'b0;
    snes_rd_n     <= 1'b1;
    snes_pawr_n   <= 1'b1;
    snes_romsel_n <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset_state();
    @(negedge CLK2);
    check_bit("reset mcu_rdy", 1'b1, mcu_rdy);
    check_bit("reset rom_we", 1'b1, rom_we);
    check_bit("reset rom_dq_oe", 1'b0, rom_dq_oe);
    check_bit("reset snes_data_oe", 1'b0, snes_data_oe);
  endtask

  task automatic test_dead_write_read();
    logic [15:0] w;
    mcu_access("dead write odd", 1'b1, 24'h000345, 8'h5a);
    mcu_access("dead write even", 1'b1, 24'h0006a2, 8'hc3);
    w = rom_mem[word_idx(24'h000345)];
    check_byte("odd low lane", 8'h5a, w[7:0]);
    check_byte("odd high lane kept", byte_t'(fill_word(word_idx(24'h000345)) >> 8), w[15:8]);
    w = rom_mem[word_idx(24'h0006a2)];
    check_byte("even high lane", 8'hc3, w[15:8]);
    check_byte("even low lane kept", byte_t'(fill_word(word_idx(24'h0006a2))), w[7:0]);
    mcu_access("dead read odd", 1'b0, 24'h000345, 8'h00);
    check_byte("dead read odd", 8'h5a, mcu_rdata);
    mcu_access("dead read even", 1'b0, 24'h0006a2, 8'h00);
    check_byte("dead read even", 8'hc3, mcu_rdata);
  endtask

  task automatic test_ready_handshake();
    logic [15:0] w;
    wait_mcu_ready("handshake");
    mcu_request(1'b0, 24'h000345, 8'h00);
    @(negedge CLK2);
    check_bit("mcu_rdy after request", 1'b0, mcu_rdy);
    @(posedge CLK2);
    mcu_wrq   <= 1'b1;  // Must be ignored
    mcu_addr  <= 24'h0007c4;
    mcu_wdata <= 8'hee;
    @(posedge CLK2);
    mcu_wrq <= 1'b0;
    wait_mcu_ready("handshake");
    check_byte("handshake read", 8'h5a, mcu_rdata);
    w = rom_mem[word_idx(24'h0007c4)];
    check_byte("ignored write high", byte_t'(fill_word(word_idx(24'h0007c4)) >> 8), w[15:8]);
    check_byte("ignored write low", byte_t'(fill_word(word_idx(24'h0007c4))), w[7:0]);
  endtask

  task automatic rom_read_case(input string name, input snes_addr_t addr);
    snes_addr_t masked;
    masked = addr & rom_mask;
    console_cycle(k_read, addr, 8'h00);
    if (!seen_oe) begin
      report_error($sformatf("%s: console data bus never driven during ROM read", name));
    end
    check_addr(name, rom_addr_t'(masked >> 1), seen_rom_addr);
    check_byte(name, lane_byte(rom_mem[word_idx(masked)], masked[0]), seen_data);
  endtask

  task automatic test_console_read();
    rom_read_case("console read odd", 24'hc01235);
    rom_read_case("console read even", 24'h800a48);
  endtask

  task automatic test_brightness();
    @(posedge CLK2);
    bright_limit <= 4'd7;
    console_cycle(k_pawr, 24'h002100, 8'h0f);
    check_bit("limit 7 write 0x0f forced", 1'b1, seen_oe);
    check_byte("limit 7 forced data", 8'h47, seen_data);
    console_cycle(k_pawr, 24'h002100, 8'h85);
    check_bit("limit 7 write 0x85 forced", 1'b0, seen_oe);
    @(posedge CLK2);
    bright_limit <= 4'd15;
    console_cycle(k_pawr, 24'h002100, 8'h0f);
    check_bit("limit 15 write 0x0f forced", 1'b0, seen_oe);
    console_cycle(k_pawr, 24'h002100, 8'h8f);
    check_bit("limit 15 write 0x8f forced", 1'b0, seen_oe);
  endtask

  task automatic test_alive_read();
    console_busy = 1'b1;
    fork
      begin
        while (console_busy) console_cycle(k_idle, 24'h7e0000, 8'h00);
      end
      begin
        repeat (2 * console_len) @(posedge CLK2);
        mcu_access("alive read", 1'b0, 24'h0006a2, 8'h00);
        check_byte("alive read", 8'hc3, mcu_rdata);
        console_busy = 1'b0;
      end
    join
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    rst_n         = 1'b0;
    snes_addr_in  = 24'h7e0000;
    snes_data_in  = 8'h00;
    snes_rd_n     = 1'b1;
    snes_wr_n     = 1'b1;
    snes_pawr_n   = 1'b1;
    snes_cpu_clk  = 1'b0;
    snes_romsel_n = 1'b1;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = 8'h00;
    rom_mask      = 24'h001fff;
    bright_limit  = 4'hf;
    cycle_cnt     = 0;
    checks        = 0;
    mismatches    = 0;
    other_errors  = 0;
    console_busy  = 1'b0;
    for (int i = 0; i < rom_words; i++) begin
      rom_mem[i] = fill_word(i);
    end
    repeat (reset_cycles) @(posedge CLK2);
    rst_n <= 1'b1;

    test_reset_state();
    test_dead_write_read();   // Console still dead here
    test_ready_handshake();
    test_console_read();
    test_brightness();
    test_alive_read();

    repeat (4) @(posedge CLK2);
    $display("Summary: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
             checks, mismatches, other_errors, u_dut.u_asserts.fail_cnt);
    if (mismatches == 0 && other_errors == 0 && u_dut.u_asserts.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== test/tb_snes_cart_asserts.sv ====
`timescale 1ns/1ps

module tb_snes_cart_asserts (
  input logic CLK2,
  input logic rst_n,
  input logic rom_bhe,
  input logic rom_ble,
  input logic mcu_rdy,
  input logic mcu_hit_rd,
  input logic mcu_hit_wr
);

  int fail_cnt = 0;  // Read by the testbench summary

  // Exactly one byte lane selected at a time
  lanes_opposite: assert property (@(posedge CLK2) disable iff (!rst_n)
    rom_bhe != rom_ble)
    else begin
      fail_cnt++;
      $error("rom_bhe and rom_ble are not opposite");
    end

  rdy_low_in_access: assert property (@(posedge CLK2) disable iff (!rst_n)
    (mcu_hit_rd || mcu_hit_wr) |-> !mcu_rdy)
    else begin
      fail_cnt++;
      $error("mcu_rdy high during an MCU ROM access");
    end

endmodule

bind snes_cart_top tb_snes_cart_asserts u_asserts (
  .CLK2      (CLK2),
  .rst_n     (rst_n),
  .rom_bhe   (rom_bhe),
  .rom_ble   (rom_ble),
  .mcu_rdy   (mcu_rdy),
  .mcu_hit_rd(mcu_hit_rd),
  .mcu_hit_wr(mcu_hit_wr)
);
